// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	typedef logic [xlen-1:0]       word_t;
	typedef logic [reg_addr_w-1:0] reg_idx_t;

	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111
	} opcode_t;

	typedef enum logic [4:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b,  // lui
		alu_pc_add,  // auipc
		alu_link,    // jal and jalr
		alu_br_eq,
		alu_br_ne,
		alu_br_lt,
		alu_br_ge,
		alu_br_ltu,
		alu_br_geu,
		alu_illegal
	} alu_op_t;

	// funct3 of the arithmetic group
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct3 of the branch group
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [6:0] funct7_alt = 7'b0100000;  // sub, sra

	localparam word_t inst_bytes = 32'd4;

endpackage

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  rv_pkg::word_t     instr,
	input  rv_pkg::word_t     pc,
	input  rv_pkg::word_t     rs1_data,
	input  rv_pkg::word_t     rs2_data,
	input  logic              busy,
	output rv_pkg::reg_idx_t  rs1_addr,
	output rv_pkg::reg_idx_t  rs2_addr,
	output logic              dec_valid,
	output rv_pkg::alu_op_t   dec_op,
	output rv_pkg::reg_idx_t  dec_rd,
	output rv_pkg::word_t     dec_a,
	output rv_pkg::word_t     dec_b,
	output rv_pkg::word_t     dec_imm,
	output rv_pkg::word_t     dec_pc
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	alu_op_t    op_nxt;
	word_t      a_nxt;
	word_t      b_nxt;
	word_t      imm_nxt;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	// shared by op and op_imm
	// immediates carry no funct7 except on shifts
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic [6:0] f7,
			input logic is_imm);
		alu_op_t res;
		logic    f7_zero;
		logic    f7_alt;
		logic    f7_ok;
		f7_zero = (f7 == 7'b0);
		f7_alt  = (f7 == funct7_alt);
		f7_ok   = is_imm | f7_zero;
		res     = alu_illegal;
		case (f3)
			f3_add: begin
				if (f7_ok)
					res = alu_add;
				else if (f7_alt && !is_imm)
					res = alu_sub;
			end
			f3_sll:  if (f7_zero) res = alu_sll;
			f3_slt:  if (f7_ok) res = alu_slt;
			f3_sltu: if (f7_ok) res = alu_sltu;
			f3_xor:  if (f7_ok) res = alu_xor;
			f3_or:   if (f7_ok) res = alu_or;
			f3_and:  if (f7_ok) res = alu_and;
			default: begin
				if (f7_zero)
					res = alu_srl;
				else if (f7_alt)
					res = alu_sra;
			end
		endcase
		return res;
	endfunction

	always_comb begin
		op_nxt  = alu_illegal;
		a_nxt   = rs1_data;
		b_nxt   = rs2_data;
		imm_nxt = imm_i;
		case (opcode)
			opc_op: op_nxt = arith_op(funct3, funct7, 1'b0);
			opc_op_imm: begin
				op_nxt = arith_op(funct3, funct7, 1'b1);
				b_nxt  = imm_i;
			end
			opc_lui: begin
				op_nxt = alu_pass_b;
				b_nxt  = imm_u;
			end
			opc_auipc: begin
				op_nxt  = alu_pc_add;
				imm_nxt = imm_u;
			end
			opc_branch: begin
				imm_nxt = imm_b;
				case (funct3)
					f3_beq:  op_nxt = alu_br_eq;
					f3_bne:  op_nxt = alu_br_ne;
					f3_blt:  op_nxt = alu_br_lt;
					f3_bge:  op_nxt = alu_br_ge;
					f3_bltu: op_nxt = alu_br_ltu;
					f3_bgeu: op_nxt = alu_br_geu;
					default: op_nxt = alu_illegal;
				endcase
			end
			opc_jal: begin
				op_nxt  = alu_link;
				a_nxt   = pc;  // target base is the pc
				imm_nxt = imm_j;
			end
			opc_jalr: begin
				if (funct3 == 3'b000)
					op_nxt = alu_link;
			end
			default: op_nxt = alu_illegal;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_op  <= op_nxt;
			dec_rd  <= instr[11:7];
			dec_a   <= a_nxt;
			dec_b   <= b_nxt;
			dec_imm <= imm_nxt;
			dec_pc  <= pc;
		end
	end

	// one instruction in flight
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> !busy);

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::reg_idx_t  rs1_addr,
	input  rv_pkg::reg_idx_t  rs2_addr,
	input  logic              wr_en,
	input  rv_pkg::reg_idx_t  wr_addr,
	input  rv_pkg::word_t     wr_data,
	output rv_pkg::word_t     rs1_data,
	output rv_pkg::word_t     rs2_data
);
	import rv_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin  // x0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// retire spacing means at most one write per instruction
	a_single_write: assert property (@(posedge clk) disable iff (rst)
		wr_en |=> !wr_en);

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  logic              clk,
	input  logic              rst,
	input  logic              dec_valid,
	input  rv_pkg::alu_op_t   dec_op,
	input  rv_pkg::reg_idx_t  dec_rd,
	input  rv_pkg::word_t     dec_a,
	input  rv_pkg::word_t     dec_b,
	input  rv_pkg::word_t     dec_imm,
	input  rv_pkg::word_t     dec_pc,
	output logic              ex_valid,
	output rv_pkg::reg_idx_t  ex_rd,
	output rv_pkg::word_t     ex_result,
	output rv_pkg::word_t     ex_next_pc,
	output logic              ex_illegal
);
	import rv_pkg::*;

	word_t seq_pc;
	word_t br_tgt;
	word_t jump_sum;
	logic  eq;
	logic  lt_s;
	logic  lt_u;
	logic  is_branch;
	logic  taken;
	logic  illegal;
	word_t result;
	word_t tgt_pc;

	assign seq_pc   = dec_pc + inst_bytes;
	assign br_tgt   = dec_pc + dec_imm;
	assign jump_sum = dec_a + dec_imm;  // dec_a is pc for jal, rs1 for jalr

	assign eq   = (dec_a == dec_b);
	assign lt_s = ($signed(dec_a) < $signed(dec_b));
	assign lt_u = (dec_a < dec_b);

	always_comb begin
		result    = '0;
		is_branch = 1'b0;
		taken     = 1'b0;
		illegal   = 1'b0;
		tgt_pc    = seq_pc;
		case (dec_op)
			alu_add:    result = dec_a + dec_b;
			alu_sub:    result = dec_a - dec_b;
			alu_xor:    result = dec_a ^ dec_b;
			alu_or:     result = dec_a | dec_b;
			alu_and:    result = dec_a & dec_b;
			alu_sll:    result = dec_a << dec_b[4:0];
			alu_srl:    result = dec_a >> dec_b[4:0];
			alu_sra:    result = $signed(dec_a) >>> dec_b[4:0];
			alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
			alu_pass_b: result = dec_b;
			alu_pc_add: result = br_tgt;  // pc plus upper immediate
			alu_link: begin
				result = seq_pc;
				tgt_pc = {jump_sum[xlen-1:1], 1'b0};
			end
			alu_br_eq: begin
				is_branch = 1'b1;
				taken     = eq;
			end
			alu_br_ne: begin
				is_branch = 1'b1;
				taken     = !eq;
			end
			alu_br_lt: begin
				is_branch = 1'b1;
				taken     = lt_s;
			end
			alu_br_ge: begin
				is_branch = 1'b1;
				taken     = !lt_s;
			end
			alu_br_ltu: begin
				is_branch = 1'b1;
				taken     = lt_u;
			end
			alu_br_geu: begin
				is_branch = 1'b1;
				taken     = !lt_u;
			end
			default: illegal = 1'b1;  // result zero, falls through
		endcase
		if (taken) begin
			tgt_pc = br_tgt;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			ex_rd      <= (is_branch || illegal) ? '0 : dec_rd;  // no write back
			ex_result  <= result;
			ex_next_pc <= tgt_pc;
			ex_illegal <= illegal;
		end
	end

	// decode's illegal class must reach the retire flag
	a_illegal_flag: assert property (@(posedge clk) disable iff (rst)
		dec_valid && dec_op == alu_illegal |=> ex_valid && ex_illegal);

endmodule

`default_nettype wire

// File: rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
	input  logic              clk,
	input  logic              rst,
	input  logic              ex_valid,
	input  rv_pkg::reg_idx_t  ex_rd,
	input  rv_pkg::word_t     ex_result,
	input  rv_pkg::word_t     ex_next_pc,
	input  logic              ex_illegal,
	output logic              wr_en,
	output rv_pkg::reg_idx_t  wr_addr,
	output rv_pkg::word_t     wr_data,
	output rv_pkg::word_t     pc,
	output logic              retire_valid,
	output rv_pkg::word_t     retire_pc,
	output rv_pkg::reg_idx_t  retire_rd,
	output rv_pkg::word_t     retire_data,
	output rv_pkg::word_t     next_pc,
	output logic              retire_illegal
);
	import rv_pkg::*;

	// write lands on the same edge as retire_valid rises
	assign wr_en   = ex_valid;
	assign wr_addr = ex_rd;
	assign wr_data = ex_result;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc           <= '0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= ex_valid;
			if (ex_valid) begin
				pc <= ex_next_pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			retire_pc      <= pc;  // pc of the retiring instruction
			retire_rd      <= ex_rd;
			retire_data    <= ex_result;
			retire_illegal <= ex_illegal;
		end
	end

	assign next_pc = pc;  // already updated at retire

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  rv_pkg::word_t     instr,
	output logic              retire_valid,
	output rv_pkg::word_t     retire_pc,
	output rv_pkg::reg_idx_t  retire_rd,
	output rv_pkg::word_t     retire_data,
	output rv_pkg::word_t     next_pc,
	output logic              retire_illegal
);
	import rv_pkg::*;

	reg_idx_t rs1_addr;
	reg_idx_t rs2_addr;
	word_t    rs1_data;
	word_t    rs2_data;
	logic     dec_valid;
	alu_op_t  dec_op;
	reg_idx_t dec_rd;
	word_t    dec_a;
	word_t    dec_b;
	word_t    dec_imm;
	word_t    dec_pc;
	logic     ex_valid;
	reg_idx_t ex_rd;
	word_t    ex_result;
	word_t    ex_next_pc;
	logic     ex_illegal;
	logic     wr_en;
	reg_idx_t wr_addr;
	word_t    wr_data;
	word_t    pc;
	wire      busy = dec_valid | ex_valid;  // instruction in flight

	rv_decode u_decode (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .busy(busy),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_rd(dec_rd), .dec_a(dec_a), .dec_b(dec_b), .dec_imm(dec_imm), .dec_pc(dec_pc)
	);

	rv_regfile u_regfile (
		.clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_execute u_execute (
		.clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_a(dec_a), .dec_b(dec_b), .dec_imm(dec_imm), .dec_pc(dec_pc),
		.ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
		.ex_next_pc(ex_next_pc), .ex_illegal(ex_illegal)
	);

	rv_result u_result (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
		.ex_next_pc(ex_next_pc), .ex_illegal(ex_illegal),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .pc(pc),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_data(retire_data), .next_pc(next_pc), .retire_illegal(retire_illegal)
	);

endmodule

`default_nettype wire

// File: rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              retire_valid,
	input  rv_pkg::word_t     retire_pc,
	input  rv_pkg::reg_idx_t  retire_rd,
	input  rv_pkg::word_t     retire_data,
	input  rv_pkg::word_t     next_pc,
	input  logic              retire_illegal,
	input  logic              exp_valid,
	input  logic [95:0]       exp_name,
	input  rv_pkg::word_t     exp_pc,
	input  rv_pkg::reg_idx_t  exp_rd,
	input  rv_pkg::word_t     exp_data,
	input  logic              exp_chk,
	input  rv_pkg::word_t     exp_next_pc,
	input  logic              exp_ill,
	output int                pass_cnt,
	output int                fail_cnt
);
	import rv_pkg::*;

	logic        pending = 1'b0;
	logic [95:0] p_name;
	word_t       p_pc;
	reg_idx_t    p_rd;
	word_t       p_data;
	logic        p_chk;
	word_t       p_next;
	logic        p_ill;
	logic        bad;

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
	end

	always @(posedge clk) begin
		if (!rst && retire_valid) begin
			if (!pending) begin
				$display("retire seen with no test waiting for it");
				fail_cnt = fail_cnt + 1;
			end else begin
				bad = 1'b0;
				if (retire_pc != p_pc) begin
					$display("mismatch %0s retire_pc expected %h actual %h", p_name, p_pc,
						retire_pc);
					bad = 1'b1;
				end
				if (retire_rd != p_rd) begin
					$display("mismatch %0s rd expected %0d actual %0d", p_name, p_rd, retire_rd);
					bad = 1'b1;
				end
				if (p_chk && retire_data != p_data) begin
					$display("mismatch %0s data expected %h actual %h", p_name, p_data,
						retire_data);
					bad = 1'b1;
				end
				if (next_pc != p_next) begin
					$display("mismatch %0s next_pc expected %h actual %h", p_name, p_next,
						next_pc);
					bad = 1'b1;
				end
				if (retire_illegal != p_ill) begin
					$display("mismatch %0s illegal expected %b actual %b", p_name, p_ill,
						retire_illegal);
					bad = 1'b1;
				end
				if (bad)
					fail_cnt = fail_cnt + 1;
				else begin
					pass_cnt = pass_cnt + 1;
					$display("pass %0s", p_name);
				end
			end
			pending = 1'b0;
		end
		// a new strobe may share the edge with the previous retire
		if (exp_valid) begin
			pending = 1'b1;
			p_name  = exp_name;
			p_pc    = exp_pc;
			p_rd    = exp_rd;
			p_data  = exp_data;
			p_chk   = exp_chk;
			p_next  = exp_next_pc;
			p_ill   = exp_ill;
		end
	end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
	import rv_pkg::*;

	localparam int period       = 40;
	localparam int reset_cycles = 10;
	localparam int margin       = 20;
	localparam int max_tests    = 64;

	logic        clk = 1'b0;
	logic        rst;
	logic        instr_valid;
	word_t       instr;
	logic        retire_valid;
	word_t       retire_pc;
	reg_idx_t    retire_rd;
	word_t       retire_data;
	word_t       next_pc;
	logic        retire_illegal;
	logic        exp_valid;
	logic [95:0] exp_name;
	word_t       exp_pc;
	reg_idx_t    exp_rd;
	word_t       exp_data;
	logic        exp_chk;
	word_t       exp_next_pc;
	logic        exp_ill;
	int          pass_cnt;
	int          fail_cnt;

	// stimulus table
	logic [95:0] t_name [max_tests];
	word_t       t_instr [max_tests];
	word_t       t_pc [max_tests];
	reg_idx_t    t_rd [max_tests];
	word_t       t_data [max_tests];
	logic        t_chk [max_tests];
	word_t       t_next [max_tests];
	logic        t_ill [max_tests];
	int          n_tests = 0;
	word_t       pc_m = '0;  // model pc
	word_t       xr [num_regs];
	int          seed;
	int          cycles = 0;
	int          limit = 0;

	always #(period / 2) clk = ~clk;

	rv_core DUT (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_data(retire_data), .next_pc(next_pc), .retire_illegal(retire_illegal)
	);

	rv_checker u_checker (
		.clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data), .next_pc(next_pc),
		.retire_illegal(retire_illegal),
		.exp_valid(exp_valid), .exp_name(exp_name), .exp_pc(exp_pc), .exp_rd(exp_rd),
		.exp_data(exp_data), .exp_chk(exp_chk), .exp_next_pc(exp_next_pc), .exp_ill(exp_ill),
		.pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
	);

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [11:0] im, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {im, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t sext12(input logic [11:0] im);
		return {{20{im[11]}}, im};
	endfunction

	task automatic add_test(input logic [95:0] nm, input word_t ins, input reg_idx_t rd,
			input word_t data, input logic chk, input word_t nxt, input logic ill);
		t_name[n_tests]  = nm;
		t_instr[n_tests] = ins;
		t_pc[n_tests]    = pc_m;
		t_rd[n_tests]    = rd;
		t_data[n_tests]  = data;
		t_chk[n_tests]   = chk;
		t_next[n_tests]  = nxt;
		t_ill[n_tests]   = ill;
		n_tests++;
		if (rd != 0 && chk && !ill)
			xr[rd] = data;
		pc_m = nxt;
	endtask

	// branch with a random even offset and a caller-decided outcome
	task automatic add_branch(input logic [95:0] nm, input logic [2:0] f3,
			input reg_idx_t rs1, input reg_idx_t rs2, input logic taken);
		logic [12:0] off;
		off = 13'($random(seed)) & ~13'd1;
		add_test(nm, enc_b(off, rs2, rs1, f3), 0, '0, 1'b0,
			taken ? pc_m + {{19{off[12]}}, off} : pc_m + 4, 1'b0);
	endtask

	task automatic build_table();
		logic [11:0] im;
		logic [11:0] im2;
		logic [19:0] u;
		logic [20:0] jo;
		im = {1'b1, 11'($random(seed))};  // negative
		add_test("addi_neg", enc_i(im, 0, f3_add, 1, opc_op_imm), 1, sext12(im), 1, pc_m + 4, 0);
		im = {1'b0, 11'($random(seed))};
		add_test("addi_pos", enc_i(im, 0, f3_add, 2, opc_op_imm), 2, sext12(im), 1, pc_m + 4, 0);
		add_test("addi_shamt", enc_i(12'hffd, 0, f3_add, 9, opc_op_imm), 9, -32'sd3, 1,
			pc_m + 4, 0);  // low five bits are 29
		add_test("add", enc_r(0, 2, 1, f3_add, 3), 3, xr[1] + xr[2], 1, pc_m + 4, 0);
		add_test("sub", enc_r(funct7_alt, 2, 1, f3_add, 4), 4, xr[1] - xr[2], 1, pc_m + 4, 0);
		add_test("xor", enc_r(0, 2, 1, f3_xor, 5), 5, xr[1] ^ xr[2], 1, pc_m + 4, 0);
		add_test("or", enc_r(0, 2, 1, f3_or, 6), 6, xr[1] | xr[2], 1, pc_m + 4, 0);
		add_test("and", enc_r(0, 2, 1, f3_and, 7), 7, xr[1] & xr[2], 1, pc_m + 4, 0);
		add_test("sll", enc_r(0, 9, 1, f3_sll, 10), 10, xr[1] << 29, 1, pc_m + 4, 0);
		add_test("srl", enc_r(0, 9, 1, f3_srl, 11), 11, xr[1] >> 29, 1, pc_m + 4, 0);
		add_test("sra", enc_r(funct7_alt, 9, 1, f3_srl, 12), 12, $signed(xr[1]) >>> 29, 1,
			pc_m + 4, 0);
		add_test("slt", enc_r(0, 2, 1, f3_slt, 13), 13, 32'd1, 1, pc_m + 4, 0);
		add_test("sltu", enc_r(0, 2, 1, f3_sltu, 13), 13, 32'd0, 1, pc_m + 4, 0);
		im = {1'b1, 11'($random(seed))};
		add_test("xori", enc_i(im, 2, f3_xor, 14, opc_op_imm), 14, xr[2] ^ sext12(im), 1,
			pc_m + 4, 0);
		add_test("ori", enc_i(im, 2, f3_or, 14, opc_op_imm), 14, xr[2] | sext12(im), 1,
			pc_m + 4, 0);
		add_test("andi", enc_i(im, 2, f3_and, 14, opc_op_imm), 14, xr[2] & sext12(im), 1,
			pc_m + 4, 0);
		add_test("slli", enc_i(12'd31, 1, f3_sll, 15, opc_op_imm), 15, xr[1] << 31, 1,
			pc_m + 4, 0);
		add_test("srli", enc_i(12'd7, 1, f3_srl, 15, opc_op_imm), 15, xr[1] >> 7, 1,
			pc_m + 4, 0);
		add_test("srai", enc_i({funct7_alt, 5'd5}, 1, f3_srl, 16, opc_op_imm), 16,
			$signed(xr[1]) >>> 5, 1, pc_m + 4, 0);
		add_test("slti", enc_i(im, 2, f3_slt, 17, opc_op_imm), 17, 32'd0, 1, pc_m + 4, 0);
		add_test("sltiu", enc_i(im, 2, f3_sltu, 18, opc_op_imm), 18, 32'd1, 1, pc_m + 4, 0);
		u = 20'($random(seed));
		add_test("lui", {u, 5'd19, 7'(opc_lui)}, 19, {u, 12'b0}, 1, pc_m + 4, 0);
		add_test("auipc", {u, 5'd20, 7'(opc_auipc)}, 20, pc_m + {u, 12'b0}, 1, pc_m + 4, 0);
		add_branch("beq_t", f3_beq, 1, 1, 1'b1);
		add_branch("beq_n", f3_beq, 1, 2, 1'b0);
		add_branch("bne_t", f3_bne, 1, 2, 1'b1);
		add_branch("bne_n", f3_bne, 1, 1, 1'b0);
		add_branch("blt_t", f3_blt, 1, 2, 1'b1);  // negative below positive
		add_branch("blt_n", f3_blt, 2, 1, 1'b0);
		add_branch("bge_t", f3_bge, 2, 1, 1'b1);
		add_branch("bge_n", f3_bge, 1, 2, 1'b0);
		add_branch("bltu_t", f3_bltu, 2, 1, 1'b1);
		add_branch("bltu_n", f3_bltu, 1, 2, 1'b0);
		add_branch("bgeu_t", f3_bgeu, 1, 2, 1'b1);
		add_branch("bgeu_n", f3_bgeu, 2, 1, 1'b0);
		jo = 21'($random(seed)) & ~21'd1;
		add_test("jal", enc_j(jo, 21), 21, pc_m + 4, 1, pc_m + {{11{jo[20]}}, jo}, 0);
		im = {1'b0, 10'($random(seed)), 1'b1};  // odd base
		add_test("addi_odd", enc_i(im, 0, f3_add, 22, opc_op_imm), 22, sext12(im), 1,
			pc_m + 4, 0);
		im2 = {11'($random(seed)), 1'b0};
		add_test("jalr", enc_i(im2, 22, 3'b000, 23, opc_jalr), 23, pc_m + 4, 1,
			(xr[22] + sext12(im2)) & ~32'd1, 0);
		add_test("addi_x0", enc_i(12'd5, 1, f3_add, 0, opc_op_imm), 0, xr[1] + 5, 1,
			pc_m + 4, 0);
		add_test("read_x0", enc_r(0, 2, 0, f3_add, 24), 24, xr[0] + xr[2], 1, pc_m + 4, 0);
		add_test("illegal", {im, 5'd1, 3'b000, 5'd2, 7'b0000000}, 0, '0, 1, pc_m + 4, 1);
		add_test("read_x2", enc_r(0, 0, 2, f3_add, 25), 25, xr[2], 1, pc_m + 4, 0);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the DUT stopped retiring", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		exp_valid   = 1'b0;
		exp_name    = '0;
		exp_pc      = '0;
		exp_rd      = '0;
		exp_data    = '0;
		exp_chk     = 1'b0;
		exp_next_pc = '0;
		exp_ill     = 1'b0;
		seed        = 32'h8d7f;
		for (int r = 0; r < num_regs; r++)
			xr[r] = '0;
		build_table();
		limit = n_tests * 6 + reset_cycles + margin;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		for (int i = 0; i < n_tests; i++) begin
			instr       = t_instr[i];
			instr_valid = 1'b1;
			exp_valid   = 1'b1;
			exp_name    = t_name[i];
			exp_pc      = t_pc[i];
			exp_rd      = t_rd[i];
			exp_data    = t_data[i];
			exp_chk     = t_chk[i];
			exp_next_pc = t_next[i];
			exp_ill     = t_ill[i];
			@(negedge clk);
			instr_valid = 1'b0;
			exp_valid   = 1'b0;
			while (!retire_valid)
				@(negedge clk);
		end
		@(posedge clk);
		@(negedge clk);
		$display("tests %0d passed %0d failed %0d", n_tests, pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == n_tests) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_checker.sv
tb_rv_core.sv

// File: run.sh
#!/bin/bash
# builds and runs the testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_rv_core \
	-o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Errors found" sim.log &&
{ echo "simulation failed"; exit 1; } ||
{ echo "simulation passed"; exit 0; }
